// ==== source/sched_pkg.sv ====
// shared widths and encodings for the RV32 issue scheduler; only the RV32I subset listed here decodes
package sched_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] pc_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [1:0]  exc_code_t;
  typedef logic [7:0]  exc_vec_t;

  // queue geometry, pointer wraps naturally at 8
  localparam int queue_depth_lp = 8;
  typedef logic [2:0] queue_ptr_t;
  typedef logic [3:0] queue_cnt_t;

  localparam int num_regs_lp = 32;

  // fetch exception codes from the front end
  localparam exc_code_t exc_access_fault_lp = 2'd0;
  localparam exc_code_t exc_misaligned_lp   = 2'd1;
  localparam exc_code_t exc_page_fault_lp   = 2'd2;

  // bit positions in the exception/special vector
  localparam int bit_access_fault_lp = 0;
  localparam int bit_misaligned_lp   = 1;
  localparam int bit_page_fault_lp   = 2;
  localparam int bit_illegal_lp      = 3;
  localparam int bit_ecall_lp        = 4;
  localparam int bit_ebreak_lp       = 5;
  localparam int bit_mret_lp         = 6;
  localparam int bit_wfi_lp          = 7;

  // major opcodes
  localparam opcode_t op_lui_lp    = 7'b0110111;
  localparam opcode_t op_jal_lp    = 7'b1101111;
  localparam opcode_t op_branch_lp = 7'b1100011;
  localparam opcode_t op_load_lp   = 7'b0000011;
  localparam opcode_t op_store_lp  = 7'b0100011;
  localparam opcode_t op_imm_lp    = 7'b0010011;
  localparam opcode_t op_reg_lp    = 7'b0110011;
  localparam opcode_t op_system_lp = 7'b1110011;

  // exact system words
  localparam instr_t instr_ecall_lp  = 32'h00000073;
  localparam instr_t instr_ebreak_lp = 32'h00100073;
  localparam instr_t instr_mret_lp   = 32'h30200073;
  localparam instr_t instr_wfi_lp    = 32'h10500073;

endpackage

// ==== source/sched_ifs.sv ====
// slot and decode bundles; yumi may only rise while v is high, and slot2 yumi needs slot1 yumi
`timescale 1ns/10ps

interface issue_slot_if
  import sched_pkg::*;
();
  logic      v;
  pc_t       pc;
  instr_t    instr;
  logic      is_exc;
  exc_code_t exc_code;
  logic      yumi;

  modport queue (output v, pc, instr, is_exc, exc_code, input yumi);
  modport consumer (input v, pc, instr, is_exc, exc_code, output yumi);
endinterface

interface decode_if
  import sched_pkg::*;
();
  xlen_t imm;
  logic  irf_w_v;
  logic  illegal;
  logic  ecall;
  logic  ebreak;
  logic  mret;
  logic  wfi;

  modport decoder (output imm, irf_w_v, illegal, ecall, ebreak, mret, wfi);
  modport sink (input imm, irf_w_v, illegal, ecall, ebreak, mret, wfi);
endinterface

// ==== source/issue_queue.sv ====
// 8-entry issue queue; messages offered while fe_ready_o is low are dropped, fe_v2_i needs fe_v1_i
`timescale 1ns/10ps

module issue_queue
  import sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       clr_i,
  input  logic       fe_v1_i,
  input  logic       fe_v2_i,
  input  logic       fe_is_exc1_i,
  input  logic       fe_is_exc2_i,
  input  pc_t        fe_pc1_i,
  input  pc_t        fe_pc2_i,
  input  instr_t     fe_instr1_i,
  input  instr_t     fe_instr2_i,
  input  exc_code_t  fe_exc_code1_i,
  input  exc_code_t  fe_exc_code2_i,
  output logic       fe_ready_o,
  issue_slot_if.queue slot1,
  issue_slot_if.queue slot2
);

  pc_t       pc_mem    [queue_depth_lp];
  instr_t    instr_mem [queue_depth_lp];
  logic      exc_mem   [queue_depth_lp];
  exc_code_t code_mem  [queue_depth_lp];

  queue_ptr_t rptr_r;
  queue_ptr_t wptr_r;
  queue_cnt_t cnt_r;
  queue_ptr_t rptr_next;
  queue_ptr_t wptr_next;
  logic       wr1;
  logic       wr2;
  queue_cnt_t n_wr;
  queue_cnt_t n_rd;

  // room for a full pair is required before taking anything
  assign fe_ready_o = (cnt_r <= queue_cnt_t'(queue_depth_lp - 2));

  assign wr1 = fe_ready_o & fe_v1_i & ~clr_i;
  assign wr2 = wr1 & fe_v2_i;
  assign n_wr = queue_cnt_t'(wr1) + queue_cnt_t'(wr2);
  assign n_rd = queue_cnt_t'(slot1.yumi) + queue_cnt_t'(slot2.yumi);

  assign rptr_next = rptr_r + 3'd1;
  assign wptr_next = wptr_r + 3'd1;

  // entry payload
  always_ff @(posedge clk_i)
  begin
    if (wr1)
    begin
      pc_mem[wptr_r]    <= fe_pc1_i;
      instr_mem[wptr_r] <= fe_instr1_i;
      exc_mem[wptr_r]   <= fe_is_exc1_i;
      code_mem[wptr_r]  <= fe_exc_code1_i;
    end
    if (wr2)
    begin
      pc_mem[wptr_next]    <= fe_pc2_i;
      instr_mem[wptr_next] <= fe_instr2_i;
      exc_mem[wptr_next]   <= fe_is_exc2_i;
      code_mem[wptr_next]  <= fe_exc_code2_i;
    end
  end

  // pointers and occupancy, flush drops everything including this cycle's writes
  always_ff @(posedge clk_i)
  begin
    if (rst_i || clr_i)
    begin
      rptr_r <= '0;
      wptr_r <= '0;
      cnt_r  <= '0;
    end
    else
    begin
      rptr_r <= rptr_r + queue_ptr_t'(n_rd);
      wptr_r <= wptr_r + queue_ptr_t'(n_wr);
      cnt_r  <= cnt_r + n_wr - n_rd;
    end
  end

  // head and head+1
  assign slot1.v        = (cnt_r != '0);
  assign slot1.pc       = pc_mem[rptr_r];
  assign slot1.instr    = instr_mem[rptr_r];
  assign slot1.is_exc   = exc_mem[rptr_r];
  assign slot1.exc_code = code_mem[rptr_r];

  assign slot2.v        = (cnt_r > queue_cnt_t'(1));
  assign slot2.pc       = pc_mem[rptr_next];
  assign slot2.instr    = instr_mem[rptr_next];
  assign slot2.is_exc   = exc_mem[rptr_next];
  assign slot2.exc_code = code_mem[rptr_next];

endmodule

// ==== source/int_regfile.sv ====
// integer register file, no write-to-read bypass, port 2 wins on a same-register write
`timescale 1ns/10ps

module int_regfile
  import sched_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      w_v1_i,
  input  logic      w_v2_i,
  input  reg_addr_t w_addr1_i,
  input  reg_addr_t w_addr2_i,
  input  xlen_t     w_data1_i,
  input  xlen_t     w_data2_i,
  input  reg_addr_t rs_addr1a_i,
  input  reg_addr_t rs_addr1b_i,
  input  reg_addr_t rs_addr2a_i,
  input  reg_addr_t rs_addr2b_i,
  output xlen_t     rs_data1a_o,
  output xlen_t     rs_data1b_o,
  output xlen_t     rs_data2a_o,
  output xlen_t     rs_data2b_o
);

  // x0 has no storage
  xlen_t regs_r [1:num_regs_lp-1];

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 1; i < num_regs_lp; i++)
      begin
        regs_r[i] <= '0;
      end
    end
    else
    begin
      if (w_v1_i && (w_addr1_i != '0))
        regs_r[w_addr1_i] <= w_data1_i;
      // later assignment takes priority
      if (w_v2_i && (w_addr2_i != '0))
        regs_r[w_addr2_i] <= w_data2_i;
    end
  end

  assign rs_data1a_o = (rs_addr1a_i == '0) ? '0 : regs_r[rs_addr1a_i];
  assign rs_data1b_o = (rs_addr1b_i == '0) ? '0 : regs_r[rs_addr1b_i];
  assign rs_data2a_o = (rs_addr2a_i == '0) ? '0 : regs_r[rs_addr2a_i];
  assign rs_data2b_o = (rs_addr2b_i == '0) ? '0 : regs_r[rs_addr2b_i];

endmodule

// ==== source/instr_decoder.sv ====
// decodes only LUI, JAL, branch, load, store, OP-IMM, OP and four SYSTEM words; all else is illegal
`timescale 1ns/10ps

module instr_decoder
  import sched_pkg::*;
(
  input  instr_t         instr_i,
  decode_if.decoder      dec
);

  opcode_t opcode;
  logic    rd_nz;
  xlen_t   imm_i;
  xlen_t   imm_s;
  xlen_t   imm_b;
  xlen_t   imm_u;
  xlen_t   imm_j;

  assign opcode = instr_i[6:0];
  assign rd_nz  = (instr_i[11:7] != 5'd0);

  // immediate formats
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb
  begin
    dec.imm     = '0;
    dec.irf_w_v = 1'b0;
    dec.illegal = 1'b0;
    dec.ecall   = 1'b0;
    dec.ebreak  = 1'b0;
    dec.mret    = 1'b0;
    dec.wfi     = 1'b0;
    // low bits other than 11 never match an opcode, so they land in default
    case (opcode)
      op_lui_lp:
      begin
        dec.imm     = imm_u;
        dec.irf_w_v = rd_nz;
      end
      op_jal_lp:
      begin
        dec.imm     = imm_j;
        dec.irf_w_v = rd_nz;
      end
      op_branch_lp:
        dec.imm = imm_b;
      op_load_lp, op_imm_lp:
      begin
        dec.imm     = imm_i;
        dec.irf_w_v = rd_nz;
      end
      op_store_lp:
        dec.imm = imm_s;
      op_reg_lp:
        dec.irf_w_v = rd_nz;
      op_system_lp:
      begin
        dec.imm = imm_i;
        case (instr_i)
          instr_ecall_lp:  dec.ecall  = 1'b1;
          instr_ebreak_lp: dec.ebreak = 1'b1;
          instr_mret_lp:   dec.mret   = 1'b1;
          instr_wfi_lp:    dec.wfi    = 1'b1;
          default:         dec.illegal = 1'b1;
        endcase
      end
      default:
        dec.illegal = 1'b1;
    endcase
  end

endmodule

// ==== source/dispatch_former.sv ====
// accept and packet forming; packet fields other than exc are meaningful only while accepted
`timescale 1ns/10ps

module dispatch_former
  import sched_pkg::*;
(
  input  logic           dispatch_v1_i,
  input  logic           dispatch_v2_i,
  input  logic           suppress_i,
  input  logic           poison_i,
  issue_slot_if.consumer slot1,
  issue_slot_if.consumer slot2,
  decode_if.sink         dec1,
  decode_if.sink         dec2,
  input  xlen_t          rs1_data1_i,
  input  xlen_t          rs2_data1_i,
  input  xlen_t          rs1_data2_i,
  input  xlen_t          rs2_data2_i,
  output logic           dispatch_v1_o,
  output pc_t            dispatch_pc1_o,
  output instr_t         dispatch_instr1_o,
  output xlen_t          dispatch_rs11_o,
  output xlen_t          dispatch_rs21_o,
  output xlen_t          dispatch_imm1_o,
  output logic           dispatch_wb_v1_o,
  output exc_vec_t       dispatch_exc1_o,
  output logic           dispatch_v2_o,
  output pc_t            dispatch_pc2_o,
  output instr_t         dispatch_instr2_o,
  output xlen_t          dispatch_rs12_o,
  output xlen_t          dispatch_rs22_o,
  output xlen_t          dispatch_imm2_o,
  output logic           dispatch_wb_v2_o,
  output exc_vec_t       dispatch_exc2_o
);

  // fetch fault bits for exception entries, decode flags otherwise
  function automatic exc_vec_t form_exc(input logic is_exc, input exc_code_t code,
                                        input logic illegal, input logic ecall,
                                        input logic ebreak, input logic mret,
                                        input logic wfi);
    exc_vec_t vec;
    vec = '0;
    if (is_exc)
    begin
      case (code)
        exc_access_fault_lp: vec[bit_access_fault_lp] = 1'b1;
        exc_misaligned_lp:   vec[bit_misaligned_lp]   = 1'b1;
        exc_page_fault_lp:   vec[bit_page_fault_lp]   = 1'b1;
        default:             vec = '0;
      endcase
    end
    else
    begin
      vec[bit_illegal_lp] = illegal;
      vec[bit_ecall_lp]   = ecall;
      vec[bit_ebreak_lp]  = ebreak;
      vec[bit_mret_lp]    = mret;
      vec[bit_wfi_lp]     = wfi;
    end
    return vec;
  endfunction

  // slot 2 only goes together with slot 1
  assign slot1.yumi = ~suppress_i & slot1.v & dispatch_v1_i;
  assign slot2.yumi = slot1.yumi & slot2.v & dispatch_v2_i;

  assign dispatch_v1_o     = slot1.yumi & ~poison_i;
  assign dispatch_pc1_o    = slot1.pc;
  assign dispatch_instr1_o = slot1.instr;
  assign dispatch_rs11_o   = slot1.is_exc ? '0 : rs1_data1_i;
  assign dispatch_rs21_o   = slot1.is_exc ? '0 : rs2_data1_i;
  assign dispatch_imm1_o   = slot1.is_exc ? '0 : dec1.imm;
  assign dispatch_wb_v1_o  = ~slot1.is_exc & dec1.irf_w_v;
  assign dispatch_exc1_o   = slot1.yumi
                           ? form_exc(slot1.is_exc, slot1.exc_code, dec1.illegal, dec1.ecall,
                                      dec1.ebreak, dec1.mret, dec1.wfi)
                           : '0;

  assign dispatch_v2_o     = slot2.yumi & ~poison_i;
  assign dispatch_pc2_o    = slot2.pc;
  assign dispatch_instr2_o = slot2.instr;
  assign dispatch_rs12_o   = slot2.is_exc ? '0 : rs1_data2_i;
  assign dispatch_rs22_o   = slot2.is_exc ? '0 : rs2_data2_i;
  assign dispatch_imm2_o   = slot2.is_exc ? '0 : dec2.imm;
  assign dispatch_wb_v2_o  = ~slot2.is_exc & dec2.irf_w_v;
  assign dispatch_exc2_o   = slot2.yumi
                           ? form_exc(slot2.is_exc, slot2.exc_code, dec2.illegal, dec2.ecall,
                                      dec2.ebreak, dec2.mret, dec2.wfi)
                           : '0;

endmodule

// ==== source/be_scheduler.sv ====
// two-wide RV32 issue scheduler top; front end must hold its messages while fe_ready_o is low
`timescale 1ns/10ps

module be_scheduler
  import sched_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      fe_v1_i,
  input  pc_t       fe_pc1_i,
  input  instr_t    fe_instr1_i,
  input  logic      fe_is_exc1_i,
  input  exc_code_t fe_exc_code1_i,
  input  logic      fe_v2_i,
  input  pc_t       fe_pc2_i,
  input  instr_t    fe_instr2_i,
  input  logic      fe_is_exc2_i,
  input  exc_code_t fe_exc_code2_i,
  output logic      fe_ready_o,
  input  logic      dispatch_v1_i,
  input  logic      dispatch_v2_i,
  input  logic      suppress_i,
  input  logic      poison_i,
  input  logic      iwb_v1_i,
  input  reg_addr_t iwb_addr1_i,
  input  xlen_t     iwb_data1_i,
  input  logic      iwb_v2_i,
  input  reg_addr_t iwb_addr2_i,
  input  xlen_t     iwb_data2_i,
  output logic      dispatch_v1_o,
  output pc_t       dispatch_pc1_o,
  output instr_t    dispatch_instr1_o,
  output xlen_t     dispatch_rs11_o,
  output xlen_t     dispatch_rs21_o,
  output xlen_t     dispatch_imm1_o,
  output logic      dispatch_wb_v1_o,
  output exc_vec_t  dispatch_exc1_o,
  output logic      dispatch_v2_o,
  output pc_t       dispatch_pc2_o,
  output instr_t    dispatch_instr2_o,
  output xlen_t     dispatch_rs12_o,
  output xlen_t     dispatch_rs22_o,
  output xlen_t     dispatch_imm2_o,
  output logic      dispatch_wb_v2_o,
  output exc_vec_t  dispatch_exc2_o
);

  issue_slot_if slot1 ();
  issue_slot_if slot2 ();
  decode_if     dec1 ();
  decode_if     dec2 ();

  xlen_t rs1_data1;
  xlen_t rs2_data1;
  xlen_t rs1_data2;
  xlen_t rs2_data2;

  issue_queue issue_queue_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .clr_i          (suppress_i),
    .fe_v1_i        (fe_v1_i),
    .fe_v2_i        (fe_v2_i),
    .fe_is_exc1_i   (fe_is_exc1_i),
    .fe_is_exc2_i   (fe_is_exc2_i),
    .fe_pc1_i       (fe_pc1_i),
    .fe_pc2_i       (fe_pc2_i),
    .fe_instr1_i    (fe_instr1_i),
    .fe_instr2_i    (fe_instr2_i),
    .fe_exc_code1_i (fe_exc_code1_i),
    .fe_exc_code2_i (fe_exc_code2_i),
    .fe_ready_o     (fe_ready_o),
    .slot1          (slot1),
    .slot2          (slot2)
  );

  // rs1 from bits 19:15, rs2 from bits 24:20
  int_regfile int_regfile_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .w_v1_i      (iwb_v1_i),
    .w_v2_i      (iwb_v2_i),
    .w_addr1_i   (iwb_addr1_i),
    .w_addr2_i   (iwb_addr2_i),
    .w_data1_i   (iwb_data1_i),
    .w_data2_i   (iwb_data2_i),
    .rs_addr1a_i (slot1.instr[19:15]),
    .rs_addr1b_i (slot1.instr[24:20]),
    .rs_addr2a_i (slot2.instr[19:15]),
    .rs_addr2b_i (slot2.instr[24:20]),
    .rs_data1a_o (rs1_data1),
    .rs_data1b_o (rs2_data1),
    .rs_data2a_o (rs1_data2),
    .rs_data2b_o (rs2_data2)
  );

  instr_decoder dec_slot1 (
    .instr_i (slot1.instr),
    .dec     (dec1)
  );

  instr_decoder dec_slot2 (
    .instr_i (slot2.instr),
    .dec     (dec2)
  );

  dispatch_former dispatch_former_i (
    .dispatch_v1_i     (dispatch_v1_i),
    .dispatch_v2_i     (dispatch_v2_i),
    .suppress_i        (suppress_i),
    .poison_i          (poison_i),
    .slot1             (slot1),
    .slot2             (slot2),
    .dec1              (dec1),
    .dec2              (dec2),
    .rs1_data1_i       (rs1_data1),
    .rs2_data1_i       (rs2_data1),
    .rs1_data2_i       (rs1_data2),
    .rs2_data2_i       (rs2_data2),
    .dispatch_v1_o     (dispatch_v1_o),
    .dispatch_pc1_o    (dispatch_pc1_o),
    .dispatch_instr1_o (dispatch_instr1_o),
    .dispatch_rs11_o   (dispatch_rs11_o),
    .dispatch_rs21_o   (dispatch_rs21_o),
    .dispatch_imm1_o   (dispatch_imm1_o),
    .dispatch_wb_v1_o  (dispatch_wb_v1_o),
    .dispatch_exc1_o   (dispatch_exc1_o),
    .dispatch_v2_o     (dispatch_v2_o),
    .dispatch_pc2_o    (dispatch_pc2_o),
    .dispatch_instr2_o (dispatch_instr2_o),
    .dispatch_rs12_o   (dispatch_rs12_o),
    .dispatch_rs22_o   (dispatch_rs22_o),
    .dispatch_imm2_o   (dispatch_imm2_o),
    .dispatch_wb_v2_o  (dispatch_wb_v2_o),
    .dispatch_exc2_o   (dispatch_exc2_o)
  );

endmodule

// ==== verification/tb_be_scheduler.sv ====
// table-driven testbench; each row is one cycle plus idle cycles that keep only its dispatch strobes
`timescale 1ns/10ps

module tb_be_scheduler
  import sched_pkg::*;
();

  logic      clk_i;
  logic      rst_i;
  logic      fe_v1_i;
  pc_t       fe_pc1_i;
  instr_t    fe_instr1_i;
  logic      fe_is_exc1_i;
  exc_code_t fe_exc_code1_i;
  logic      fe_v2_i;
  pc_t       fe_pc2_i;
  instr_t    fe_instr2_i;
  logic      fe_is_exc2_i;
  exc_code_t fe_exc_code2_i;
  logic      fe_ready_o;
  logic      dispatch_v1_i;
  logic      dispatch_v2_i;
  logic      suppress_i;
  logic      poison_i;
  logic      iwb_v1_i;
  reg_addr_t iwb_addr1_i;
  xlen_t     iwb_data1_i;
  logic      iwb_v2_i;
  reg_addr_t iwb_addr2_i;
  xlen_t     iwb_data2_i;
  logic      dispatch_v1_o;
  pc_t       dispatch_pc1_o;
  instr_t    dispatch_instr1_o;
  xlen_t     dispatch_rs11_o;
  xlen_t     dispatch_rs21_o;
  xlen_t     dispatch_imm1_o;
  logic      dispatch_wb_v1_o;
  exc_vec_t  dispatch_exc1_o;
  logic      dispatch_v2_o;
  pc_t       dispatch_pc2_o;
  instr_t    dispatch_instr2_o;
  xlen_t     dispatch_rs12_o;
  xlen_t     dispatch_rs22_o;
  xlen_t     dispatch_imm2_o;
  logic      dispatch_wb_v2_o;
  exc_vec_t  dispatch_exc2_o;

  // fetch messages with their expected decode results
  pc_t       msg_pc [$];
  instr_t    msg_instr [$];
  logic      msg_exc [$];
  exc_code_t msg_code [$];
  xlen_t     msg_imm [$];
  logic      msg_wb [$];
  exc_vec_t  msg_vec [$];

  // cycle rows with ctl as {dispatch_v1, dispatch_v2, suppress, poison}
  int         row_m1 [$];
  int         row_m2 [$];
  logic [3:0] row_ctl [$];
  logic       row_w1v [$];
  reg_addr_t  row_w1a [$];
  xlen_t      row_w1d [$];
  logic       row_w2v [$];
  reg_addr_t  row_w2a [$];
  xlen_t      row_w2d [$];
  int         row_idle [$];

  // reference model state
  int    model_q [$];
  xlen_t ref_regs [num_regs_lp];

  int         cur_m1;
  int         cur_m2;
  logic [3:0] cur_ctl;
  logic       cur_w1v;
  reg_addr_t  cur_w1a;
  xlen_t      cur_w1d;
  logic       cur_w2v;
  reg_addr_t  cur_w2a;
  xlen_t      cur_w2d;
  int         seed;

  be_scheduler be_scheduler_i (.*);

  task automatic add_msg(input pc_t pc, input instr_t ins, input logic exc, input exc_code_t code,
                         input xlen_t imm, input logic wb, input exc_vec_t vec);
    msg_pc.push_back(pc);
    msg_instr.push_back(ins);
    msg_exc.push_back(exc);
    msg_code.push_back(code);
    msg_imm.push_back(imm);
    msg_wb.push_back(wb);
    msg_vec.push_back(vec);
  endtask

  task automatic add_row(input int m1, input int m2, input logic [3:0] ctl,
                         input logic w1v, input reg_addr_t w1a, input xlen_t w1d,
                         input logic w2v, input reg_addr_t w2a, input xlen_t w2d,
                         input int idle);
    row_m1.push_back(m1);
    row_m2.push_back(m2);
    row_ctl.push_back(ctl);
    row_w1v.push_back(w1v);
    row_w1a.push_back(w1a);
    row_w1d.push_back(w1d);
    row_w2v.push_back(w2v);
    row_w2a.push_back(w2a);
    row_w2d.push_back(w2d);
    row_idle.push_back(idle);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic compare_packet(input string sfx, input int idx, input pc_t pc, input instr_t ins,
                                input xlen_t rs1, input xlen_t rs2, input xlen_t imm,
                                input logic wb);
    instr_t e_ins;
    xlen_t  e_rs1;
    xlen_t  e_rs2;
    e_ins = msg_instr[idx];
    e_rs1 = msg_exc[idx] ? '0 : ref_regs[e_ins[19:15]];
    e_rs2 = msg_exc[idx] ? '0 : ref_regs[e_ins[24:20]];
    check_val({"dispatch_pc", sfx, "_o"}, pc, msg_pc[idx]);
    check_val({"dispatch_instr", sfx, "_o"}, ins, e_ins);
    check_val({"dispatch_rs1", sfx, "_o"}, rs1, e_rs1);
    check_val({"dispatch_rs2", sfx, "_o"}, rs2, e_rs2);
    check_val({"dispatch_imm", sfx, "_o"}, imm, msg_imm[idx]);
    check_val({"dispatch_wb_v", sfx, "_o"}, 32'(wb), 32'(msg_wb[idx]));
  endtask

  task automatic build_table();
    int        base;
    logic [31:0] r;
    logic [31:0] r2;
    reg_addr_t rd;
    add_msg(32'h100, 32'hFFD08293, 1'b0, 2'd0, 32'hFFFFFFFD, 1'b1, 8'h00);
    add_msg(32'h104, 32'h12345337, 1'b0, 2'd0, 32'h12345000, 1'b1, 8'h00);
    add_msg(32'h108, 32'h002083B3, 1'b0, 2'd0, 32'h00000000, 1'b1, 8'h00);
    add_msg(32'h10C, 32'hFE322C23, 1'b0, 2'd0, 32'hFFFFFFF8, 1'b0, 8'h00);
    add_msg(32'h110, 32'hFE208EE3, 1'b0, 2'd0, 32'hFFFFFFFC, 1'b0, 8'h00);
    add_msg(32'h114, 32'h008000EF, 1'b0, 2'd0, 32'h00000008, 1'b1, 8'h00);
    // load to x0 writes nothing
    add_msg(32'h118, 32'h0041A003, 1'b0, 2'd0, 32'h00000004, 1'b0, 8'h00);
    add_msg(32'h11C, instr_ecall_lp, 1'b0, 2'd0, 32'h00000000, 1'b0, 8'h10);
    add_msg(32'h120, instr_ebreak_lp, 1'b0, 2'd0, 32'h00000001, 1'b0, 8'h20);
    add_msg(32'h124, instr_mret_lp, 1'b0, 2'd0, 32'h00000302, 1'b0, 8'h40);
    add_msg(32'h128, instr_wfi_lp, 1'b0, 2'd0, 32'h00000105, 1'b0, 8'h80);
    add_msg(32'h12C, 32'h0000000B, 1'b0, 2'd0, 32'h00000000, 1'b0, 8'h08);
    add_msg(32'h130, 32'h00108090, 1'b0, 2'd0, 32'h00000000, 1'b0, 8'h08);
    add_msg(32'h134, 32'h00000000, 1'b1, exc_access_fault_lp, '0, 1'b0, 8'h01);
    add_msg(32'h136, 32'h00000000, 1'b1, exc_misaligned_lp, '0, 1'b0, 8'h02);
    add_msg(32'h138, 32'h00000000, 1'b1, exc_page_fault_lp, '0, 1'b0, 8'h04);
    // csrrw is outside the decoded subset
    add_msg(32'h13C, 32'h30001073, 1'b0, 2'd0, 32'h00000300, 1'b0, 8'h08);

    // execution side ready while the queue is still empty
    add_row(-1, -1, 4'b1100, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 2);
    add_row(-1, -1, 4'b0000, 1'b1, 5'd1, 32'h11111111, 1'b1, 5'd2, 32'h22222222, 0);
    add_row(-1, -1, 4'b0000, 1'b1, 5'd3, 32'hAAAA0000, 1'b1, 5'd3, 32'hBBBB0003, 0);
    add_row(-1, -1, 4'b0000, 1'b1, 5'd0, 32'hFFFFFFFF, 1'b1, 5'd4, 32'h00000040, 0);
    add_row(0, 1, 4'b1100, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(2, 3, 4'b1100, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(4, 5, 4'b1000, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(-1, -1, 4'b1000, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(-1, -1, 4'b1100, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(6, 7, 4'b0000, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(8, 9, 4'b1100, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(10, 11, 4'b1100, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(12, 13, 4'b1100, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(14, 15, 4'b1100, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(16, -1, 4'b1100, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(-1, -1, 4'b1100, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 1);
    // fill with dispatch held off, then one dropped pair and a flush
    add_row(0, 1, 4'b0000, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(2, 3, 4'b0000, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(4, 5, 4'b0000, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(6, 7, 4'b0000, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(8, 9, 4'b0000, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(10, 11, 4'b1110, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(-1, -1, 4'b1100, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 1);
    // flush while ready discards the offered pair
    add_row(2, 3, 4'b0010, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    // poisoned accept still dequeues
    add_row(0, 1, 4'b0000, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(-1, -1, 4'b1001, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);
    add_row(-1, -1, 4'b1000, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 0);

    // random register-register ops with random write-back traffic
    for (int i = 0; i < 6; i++)
    begin
      base = msg_pc.size();
      r  = $random(seed);
      r2 = $random(seed);
      rd = (r[4:0] == 5'd0) ? 5'd9 : r[4:0];
      add_msg(pc_t'(32'h200 + 8 * i), {7'b0, r[14:10], r[9:5], 3'b000, rd, op_reg_lp},
              1'b0, 2'd0, '0, 1'b1, 8'h00);
      add_msg(pc_t'(32'h204 + 8 * i), {7'b0, r2[14:10], r2[9:5], 3'b000, rd, op_reg_lp},
              1'b0, 2'd0, '0, 1'b1, 8'h00);
      add_row(base, base + 1, {r[20], r[21], 2'b00}, r[22], r[27:23], $random(seed),
              r2[22], r2[27:23], $random(seed), 0);
    end
    add_row(-1, -1, 4'b1100, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 4);
  endtask

  task automatic apply_cycle();
    int   k1;
    int   k2;
    int   n;
    logic y1;
    logic y2;
    k1 = (cur_m1 < 0) ? 0 : cur_m1;
    k2 = (cur_m2 < 0) ? 0 : cur_m2;
    @(posedge clk_i);
    fe_v1_i        <= (cur_m1 >= 0);
    fe_pc1_i       <= msg_pc[k1];
    fe_instr1_i    <= msg_instr[k1];
    fe_is_exc1_i   <= msg_exc[k1];
    fe_exc_code1_i <= msg_code[k1];
    fe_v2_i        <= (cur_m2 >= 0);
    fe_pc2_i       <= msg_pc[k2];
    fe_instr2_i    <= msg_instr[k2];
    fe_is_exc2_i   <= msg_exc[k2];
    fe_exc_code2_i <= msg_code[k2];
    dispatch_v1_i  <= cur_ctl[3];
    dispatch_v2_i  <= cur_ctl[2];
    suppress_i     <= cur_ctl[1];
    poison_i       <= cur_ctl[0];
    iwb_v1_i       <= cur_w1v;
    iwb_addr1_i    <= cur_w1a;
    iwb_data1_i    <= cur_w1d;
    iwb_v2_i       <= cur_w2v;
    iwb_addr2_i    <= cur_w2a;
    iwb_data2_i    <= cur_w2d;

    // outputs are settled half a cycle later
    @(negedge clk_i);
    n  = model_q.size();
    y1 = ~cur_ctl[1] & (n >= 1) & cur_ctl[3];
    y2 = y1 & (n >= 2) & cur_ctl[2];
    check_val("fe_ready_o", 32'(fe_ready_o), 32'(n <= queue_depth_lp - 2));
    check_val("dispatch_v1_o", 32'(dispatch_v1_o), 32'(y1 & ~cur_ctl[0]));
    check_val("dispatch_v2_o", 32'(dispatch_v2_o), 32'(y2 & ~cur_ctl[0]));
    check_val("dispatch_exc1_o", 32'(dispatch_exc1_o), y1 ? 32'(msg_vec[model_q[0]]) : 32'd0);
    check_val("dispatch_exc2_o", 32'(dispatch_exc2_o), y2 ? 32'(msg_vec[model_q[1]]) : 32'd0);
    if (y1)
      compare_packet("1", model_q[0], dispatch_pc1_o, dispatch_instr1_o, dispatch_rs11_o,
                     dispatch_rs21_o, dispatch_imm1_o, dispatch_wb_v1_o);
    if (y2)
      compare_packet("2", model_q[1], dispatch_pc2_o, dispatch_instr2_o, dispatch_rs12_o,
                     dispatch_rs22_o, dispatch_imm2_o, dispatch_wb_v2_o);

    // state the DUT takes at the coming edge
    if (cur_ctl[1])
      model_q.delete();
    else
    begin
      if (y1)
        void'(model_q.pop_front());
      if (y2)
        void'(model_q.pop_front());
      if ((n <= queue_depth_lp - 2) && (cur_m1 >= 0))
      begin
        model_q.push_back(cur_m1);
        if (cur_m2 >= 0)
          model_q.push_back(cur_m2);
      end
    end
    if (cur_w1v && (cur_w1a != 5'd0))
      ref_regs[cur_w1a] = cur_w1d;
    if (cur_w2v && (cur_w2a != 5'd0))
      ref_regs[cur_w2a] = cur_w2d;
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial
  begin
    #1;
    repeat (row_m1.size() * 40) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", row_m1.size() * 40);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    seed = 60422;
    build_table();
    rst_i          = 1'b1;
    fe_v1_i        = 1'b0;
    fe_pc1_i       = '0;
    fe_instr1_i    = '0;
    fe_is_exc1_i   = 1'b0;
    fe_exc_code1_i = '0;
    fe_v2_i        = 1'b0;
    fe_pc2_i       = '0;
    fe_instr2_i    = '0;
    fe_is_exc2_i   = 1'b0;
    fe_exc_code2_i = '0;
    dispatch_v1_i  = 1'b0;
    dispatch_v2_i  = 1'b0;
    suppress_i     = 1'b0;
    poison_i       = 1'b0;
    iwb_v1_i       = 1'b0;
    iwb_addr1_i    = '0;
    iwb_data1_i    = '0;
    iwb_v2_i       = 1'b0;
    iwb_addr2_i    = '0;
    iwb_data2_i    = '0;
    for (int i = 0; i < num_regs_lp; i++)
      ref_regs[i] = '0;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;

    for (int r = 0; r < row_m1.size(); r++)
    begin
      cur_m1  = row_m1[r];
      cur_m2  = row_m2[r];
      cur_ctl = row_ctl[r];
      cur_w1v = row_w1v[r];
      cur_w1a = row_w1a[r];
      cur_w1d = row_w1d[r];
      cur_w2v = row_w2v[r];
      cur_w2a = row_w2a[r];
      cur_w2d = row_w2d[r];
      apply_cycle();
      // idle cycles keep the dispatch strobes only
      cur_m1  = -1;
      cur_m2  = -1;
      cur_ctl = cur_ctl & 4'b1100;
      cur_w1v = 1'b0;
      cur_w2v = 1'b0;
      for (int j = 0; j < row_idle[r]; j++)
        apply_cycle();
    end

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== build.f ====
source/sched_pkg.sv
source/sched_ifs.sv
source/issue_queue.sv
source/int_regfile.sv
source/instr_decoder.sv
source/dispatch_former.sv
source/be_scheduler.sv
verification/tb_be_scheduler.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_be_scheduler \
  -o tb_be_scheduler
./obj_dir/tb_be_scheduler > sim.log 2>&1 || true
cat sim.log
grep -q "all tests passed" sim.log
echo "simulation passed"
